//--- hw/cpu16_config.svh
// *************************************************************************
// Widths are fixed by the 16-bit ISA and the values here must not change
// *************************************************************************
`ifndef CPU16_CONFIG_SVH
`define CPU16_CONFIG_SVH

// Data path and address width in bits, instructions are one word
`define CPU16_WIDTH 16

// Architectural registers, r0 is hardwired to zero
`define CPU16_NREGS 16

// First fetch address after rst_n is released
`define CPU16_RESET_PC 16'h0000

`endif

//--- hw/cpu16_pkg.sv
// *************************************************************************
// Encodings follow the 4-bit opcode map of the decoder, values are fixed
// *************************************************************************
package cpu16_pkg;

    // Major opcode found in instr[15:12]
    typedef enum logic [3:0] {
        OP_ADD = 4'h0, OP_SUB = 4'h1, OP_XOR = 4'h2, OP_RED    = 4'h3,
        OP_SLL = 4'h4, OP_SRA = 4'h5, OP_ROR = 4'h6, OP_PADDSB = 4'h7,
        OP_LW  = 4'h8, OP_SW  = 4'h9, OP_LLB = 4'ha, OP_LHB    = 4'hb,
        OP_B   = 4'hc, OP_BR  = 4'hd, OP_PCS = 4'he, OP_HLT    = 4'hf
    } opcode_e;

    // ALU function select
    // The first eight codes line up with the arithmetic opcodes on purpose
    typedef enum logic [3:0] {
        ALU_ADD = 4'h0, ALU_SUB = 4'h1, ALU_XOR = 4'h2, ALU_RED    = 4'h3,
        ALU_SLL = 4'h4, ALU_SRA = 4'h5, ALU_ROR = 4'h6, ALU_PADDSB = 4'h7,
        ALU_LLB = 4'h8, ALU_LHB = 4'h9
    } alu_op_e;

    // Source of the next PC
    typedef enum logic [1:0] {
        // PC + 2
        NPC_SEQ  = 2'b00,
        // PC + 2 + 2 * sext(imm9) when the condition holds
        NPC_REL  = 2'b01,
        // Register rs when the condition holds
        NPC_REG  = 2'b10,
        // Hold the PC on the HLT word
        NPC_HALT = 2'b11
    } next_pc_e;

    // Branch condition found in instr[11:9]
    typedef enum logic [2:0] {
        COND_NE = 3'b000, COND_EQ = 3'b001, COND_GT = 3'b010, COND_LT = 3'b011,
        COND_GE = 3'b100, COND_LE = 3'b101, COND_OV = 3'b110, COND_UN = 3'b111
    } cond_e;

endpackage

//--- hw/ctrl_if.sv
// *************************************************************************
// Decoded control for the instruction in flight, valid in the same cycle
// *************************************************************************
`timescale 1ns/1ns

interface ctrl_if import cpu16_pkg::*; ();

    logic     reg_write;
    logic     alu_src_imm;
    logic     mem_enable;
    logic     mem_write;
    logic     mem_to_reg;
    next_pc_e next_pc;
    // High selects the 8-bit immediate field, low the 4-bit one
    logic     imm_wide;
    // Write-back takes PC + 2 instead of ALU or memory data
    logic     pc_read;
    // The rs read port is steered to the rd field
    logic     rd_as_src;
    alu_op_e  alu_op;
    // Flag update enables, zvn wins over z when both are set
    logic     flag_we_zvn;
    logic     flag_we_z;

    // The decoder owns every signal
    modport decoder (
        output reg_write, alu_src_imm, mem_enable, mem_write, mem_to_reg, next_pc,
        output imm_wide, pc_read, rd_as_src, alu_op, flag_we_zvn, flag_we_z
    );

    // Everything downstream of the decoder only reads
    modport datapath (
        input reg_write, alu_src_imm, mem_enable, mem_write, mem_to_reg, next_pc,
        input imm_wide, pc_read, rd_as_src, alu_op, flag_we_zvn, flag_we_z
    );

endinterface

//--- hw/control.sv
// *************************************************************************
// Pure decode of the opcode, every opcode yields fully defined controls
// *************************************************************************
`timescale 1ns/1ns

module control import cpu16_pkg::*; (
    input  opcode_e   opcode,
    ctrl_if.decoder   ctrl
);

    always_comb begin
        // Defaults describe a no-op that falls through to PC + 2
        ctrl.reg_write   = 1'b0;
        ctrl.alu_src_imm = 1'b0;
        ctrl.mem_enable  = 1'b0;
        ctrl.mem_write   = 1'b0;
        ctrl.mem_to_reg  = 1'b0;
        ctrl.next_pc     = NPC_SEQ;
        ctrl.imm_wide    = 1'b0;
        ctrl.pc_read     = 1'b0;
        ctrl.rd_as_src   = 1'b0;
        ctrl.alu_op      = ALU_ADD;
        ctrl.flag_we_zvn = 1'b0;
        ctrl.flag_we_z   = 1'b0;

        case (opcode)
            // Arithmetic sets all three flags
            OP_ADD, OP_SUB, OP_PADDSB: begin
                ctrl.reg_write   = 1'b1;
                ctrl.alu_op      = alu_op_e'(opcode);
                ctrl.flag_we_zvn = 1'b1;
            end
            OP_XOR: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_op    = ALU_XOR;
                ctrl.flag_we_z = 1'b1;
            end
            // RED leaves the flags alone
            OP_RED: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_op    = ALU_RED;
            end
            // Shift amount comes from the 4-bit immediate
            OP_SLL, OP_SRA, OP_ROR: begin
                ctrl.reg_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                ctrl.alu_op      = alu_op_e'(opcode);
                ctrl.flag_we_z   = 1'b1;
            end
            // The address has its own adder in the top level, the ALU idles
            OP_LW: begin
                ctrl.reg_write  = 1'b1;
                ctrl.mem_enable = 1'b1;
                ctrl.mem_to_reg = 1'b1;
            end
            OP_SW: begin
                ctrl.mem_enable = 1'b1;
                ctrl.mem_write  = 1'b1;
            end
            // Byte loads read rd back so the other byte is kept
            OP_LLB, OP_LHB: begin
                ctrl.reg_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                ctrl.imm_wide    = 1'b1;
                ctrl.rd_as_src   = 1'b1;
                ctrl.alu_op      = (opcode == OP_LLB) ? ALU_LLB : ALU_LHB;
            end
            OP_B:  ctrl.next_pc = NPC_REL;
            OP_BR: ctrl.next_pc = NPC_REG;
            OP_PCS: begin
                ctrl.reg_write = 1'b1;
                ctrl.pc_read   = 1'b1;
            end
            OP_HLT: ctrl.next_pc = NPC_HALT;
            default: ;
        endcase

        // PC + 2 and memory data share the write-back path, only one may win
        assert (!(ctrl.pc_read && ctrl.mem_enable))
            else $error("control: pc_read and mem_enable both set");
    end

endmodule

//--- hw/alu.sv
// *************************************************************************
// Combinational, flags are raw and only stored when the decoder says so
// *************************************************************************
`timescale 1ns/1ns
`include "cpu16_config.svh"

module alu import cpu16_pkg::*; (
    input  alu_op_e                 op,
    input  logic [`CPU16_WIDTH-1:0] a,
    input  logic [`CPU16_WIDTH-1:0] b,
    output logic [`CPU16_WIDTH-1:0] result,
    output logic                    z,
    output logic                    v,
    output logic                    n
);

    localparam int W = `CPU16_WIDTH;

    logic [W-1:0]   sum;
    logic [W-1:0]   diff;
    logic           sum_ovf;
    logic           diff_ovf;
    logic [W-1:0]   sat_val;
    logic [W-1:0]   red_sum;
    logic [W-1:0]   padd;
    logic [3:0]     lane_ovf;
    logic [2*W-1:0] ror_full;

    assign sum  = a + b;
    assign diff = a - b;

    // Signed overflow seen from the operand and result signs
    assign sum_ovf  = (a[W-1] == b[W-1]) && (sum[W-1] != a[W-1]);
    assign diff_ovf = (a[W-1] != b[W-1]) && (diff[W-1] != a[W-1]);

    // Overflow always goes in the direction of a's sign for both add and sub
    assign sat_val = a[W-1] ? {1'b1, {(W-1){1'b0}}} : {1'b0, {(W-1){1'b1}}};

    // Four sign-extended bytes summed into one word
    assign red_sum = {{(W-8){a[15]}}, a[15:8]} + {{(W-8){a[7]}}, a[7:0]}
                   + {{(W-8){b[15]}}, b[15:8]} + {{(W-8){b[7]}}, b[7:0]};

    // Each nibble lane saturates on its own to 4'h7 or 4'h8
    for (genvar i = 0; i < 4; i++) begin : g_lane
        logic [3:0] an;
        logic [3:0] bn;
        logic [3:0] s;
        assign an          = a[4*i +: 4];
        assign bn          = b[4*i +: 4];
        assign s           = an + bn;
        assign lane_ovf[i] = (an[3] == bn[3]) && (s[3] != an[3]);
        assign padd[4*i +: 4] = lane_ovf[i] ? (an[3] ? 4'h8 : 4'h7) : s;
    end

    // Rotating a doubled word right leaves the rotation in the low half
    assign ror_full = {a, a} >> b[3:0];

    always_comb begin
        result = sum;
        v      = 1'b0;
        case (op)
            ALU_ADD: begin
                result = sum_ovf ? sat_val : sum;
                v      = sum_ovf;
            end
            ALU_SUB: begin
                result = diff_ovf ? sat_val : diff;
                v      = diff_ovf;
            end
            ALU_XOR: result = a ^ b;
            ALU_RED: result = red_sum;
            ALU_SLL: result = a << b[3:0];
            ALU_SRA: result = W'($signed(a) >>> b[3:0]);
            ALU_ROR: result = ror_full[W-1:0];
            ALU_PADDSB: begin
                result = padd;
                v      = |lane_ovf;
            end
            ALU_LLB: result = {a[15:8], b[7:0]};
            ALU_LHB: result = {b[7:0], a[7:0]};
            default: ;
        endcase
    end

    assign z = (result == '0);
    assign n = result[W-1];

endmodule

//--- hw/reg_file.sv
// *************************************************************************
// Write at the clock edge, reads are combinational and see no bypass
// *************************************************************************
`timescale 1ns/1ns
`include "cpu16_config.svh"

module reg_file (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic [$clog2(`CPU16_NREGS)-1:0]   rs_addr,
    input  logic [$clog2(`CPU16_NREGS)-1:0]   rt_addr,
    output logic [`CPU16_WIDTH-1:0]           rs_data,
    output logic [`CPU16_WIDTH-1:0]           rt_data,
    input  logic                              we,
    input  logic [$clog2(`CPU16_NREGS)-1:0]   wd_addr,
    input  logic [`CPU16_WIDTH-1:0]           wd_data
);

    logic [`CPU16_WIDTH-1:0] regs [`CPU16_NREGS];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `CPU16_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (wd_addr != '0)) begin
            // r0 is never written, so it keeps its reset value of zero
            regs[wd_addr] <= wd_data;
        end
    end

    assign rs_data = regs[rs_addr];
    assign rt_data = regs[rt_addr];

    // Holds across every earlier write attempt to r0, on both ports
    a_r0_zero: assert property (@(posedge clk) disable iff (!rst_n)
        ((rs_addr != '0) || (rs_data == '0)) && ((rt_addr != '0) || (rt_data == '0)))
        else $error("reg_file: r0 read back nonzero");

endmodule

//--- hw/pc_unit.sv
// *************************************************************************
// Halt is sticky until rst_n, flags only change under decoder enables
// *************************************************************************
`timescale 1ns/1ns
`include "cpu16_config.svh"

module pc_unit import cpu16_pkg::*; (
    input  logic                    clk,
    input  logic                    rst_n,
    ctrl_if.datapath                ctrl,
    input  cond_e                   cond,
    input  logic [8:0]              offset,
    input  logic [`CPU16_WIDTH-1:0] target,
    input  logic                    z_in,
    input  logic                    v_in,
    input  logic                    n_in,
    output logic [`CPU16_WIDTH-1:0] pc,
    output logic [`CPU16_WIDTH-1:0] pc_plus2,
    output logic                    halted
);

    localparam int W = `CPU16_WIDTH;

    logic         z_q;
    logic         v_q;
    logic         n_q;
    logic         taken;
    logic [W-1:0] pc_rel;
    logic [W-1:0] pc_next;

    assign pc_plus2 = pc + W'(2);

    // Word offset, sign extended and doubled into a byte offset
    assign pc_rel = pc_plus2 + {{(W-10){offset[8]}}, offset, 1'b0};

    // Conditions look at the flags stored by earlier instructions
    always_comb begin
        taken = 1'b1;
        case (cond)
            COND_NE: taken = !z_q;
            COND_EQ: taken = z_q;
            COND_GT: taken = !z_q && !n_q;
            COND_LT: taken = n_q;
            COND_GE: taken = z_q || !n_q;
            COND_LE: taken = z_q || n_q;
            COND_OV: taken = v_q;
            COND_UN: taken = 1'b1;
            default: ;
        endcase
    end

    always_comb begin
        pc_next = pc_plus2;
        case (ctrl.next_pc)
            NPC_SEQ:  pc_next = pc_plus2;
            NPC_REL:  pc_next = taken ? pc_rel : pc_plus2;
            NPC_REG:  pc_next = taken ? target : pc_plus2;
            NPC_HALT: pc_next = pc;
            default: ;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc     <= `CPU16_RESET_PC;
            halted <= 1'b0;
            z_q    <= 1'b0;
            v_q    <= 1'b0;
            n_q    <= 1'b0;
        end else if (!halted) begin
            pc <= pc_next;
            // HLT leaves the PC on its own address, halted follows one edge later
            if (ctrl.next_pc == NPC_HALT) begin
                halted <= 1'b1;
            end
            if (ctrl.flag_we_zvn) begin
                z_q <= z_in;
                v_q <= v_in;
                n_q <= n_in;
            end else if (ctrl.flag_we_z) begin
                z_q <= z_in;
            end
        end
    end

    // Once halted the core is frozen on the HLT word until reset
    a_halt_freeze: assert property (@(posedge clk) disable iff (!rst_n)
        halted |=> (halted && $stable(pc)))
        else $error("pc_unit: PC moved while halted");

endmodule

//--- hw/cpu16.sv
// *************************************************************************
// Single cycle, both memories must answer in the cycle of the access
// *************************************************************************
`timescale 1ns/1ns
`include "cpu16_config.svh"

module cpu16 import cpu16_pkg::*; (
    input  logic                    clk,
    input  logic                    rst_n,
    output logic [`CPU16_WIDTH-1:0] imem_addr,
    input  logic [`CPU16_WIDTH-1:0] imem_data,
    output logic                    dmem_en,
    output logic                    dmem_we,
    output logic [`CPU16_WIDTH-1:0] dmem_addr,
    output logic [`CPU16_WIDTH-1:0] dmem_wdata,
    input  logic [`CPU16_WIDTH-1:0] dmem_rdata,
    output logic                    halted
);

    localparam int W  = `CPU16_WIDTH;
    localparam int RA = $clog2(`CPU16_NREGS);

    ctrl_if ctrl ();

    opcode_e       opcode;
    logic [RA-1:0] rs_addr;
    logic [RA-1:0] rt_addr;
    logic [W-1:0]  rs_data;
    logic [W-1:0]  rt_data;
    logic [W-1:0]  imm;
    logic [W-1:0]  alu_b;
    logic [W-1:0]  alu_result;
    logic [W-1:0]  wb_data;
    logic [W-1:0]  pc;
    logic [W-1:0]  pc_plus2;
    logic          z;
    logic          v;
    logic          n;

    assign imem_addr = pc;
    assign opcode    = opcode_e'(imem_data[15:12]);

    // Byte loads read rd, SW reads its data register from the rd field too
    assign rs_addr = ctrl.rd_as_src ? imem_data[11:8] : imem_data[7:4];
    assign rt_addr = ctrl.mem_write ? imem_data[11:8] : imem_data[3:0];

    // The 8-bit field goes in raw for LLB and LHB
    assign imm   = ctrl.imm_wide ? {{(W-8){1'b0}}, imem_data[7:0]}
                                 : {{(W-4){1'b0}}, imem_data[3:0]};
    assign alu_b = ctrl.alu_src_imm ? imm : rt_data;

    // Plain wrapping adder, the ALU add would saturate the address
    assign dmem_addr  = rs_data + {{(W-5){imem_data[3]}}, imem_data[3:0], 1'b0};
    assign dmem_wdata = rt_data;

    // Nothing reaches the data memory in reset or after HLT
    assign dmem_en = ctrl.mem_enable && !halted && rst_n;
    assign dmem_we = ctrl.mem_write && !halted && rst_n;

    assign wb_data = ctrl.pc_read    ? pc_plus2   :
                     ctrl.mem_to_reg ? dmem_rdata : alu_result;

    control u_control (
        .opcode (opcode),
        .ctrl   (ctrl.decoder)
    );

    reg_file u_reg_file (
        .clk     (clk),
        .rst_n   (rst_n),
        .rs_addr (rs_addr),
        .rt_addr (rt_addr),
        .rs_data (rs_data),
        .rt_data (rt_data),
        .we      (ctrl.reg_write && !halted),
        .wd_addr (imem_data[11:8]),
        .wd_data (wb_data)
    );

    alu u_alu (
        .op     (ctrl.alu_op),
        .a      (rs_data),
        .b      (alu_b),
        .result (alu_result),
        .z      (z),
        .v      (v),
        .n      (n)
    );

    // BR jumps to rs, which sits in the normal rs field
    pc_unit u_pc_unit (
        .clk      (clk),
        .rst_n    (rst_n),
        .ctrl     (ctrl.datapath),
        .cond     (cond_e'(imem_data[11:9])),
        .offset   (imem_data[8:0]),
        .target   (rs_data),
        .z_in     (z),
        .v_in     (v),
        .n_in     (n),
        .pc       (pc),
        .pc_plus2 (pc_plus2),
        .halted   (halted)
    );

endmodule

//--- bench/cpu16_checker.sv
// *************************************************************************
// ISA model checked at the falling edge, load data is taken from the port
// *************************************************************************
`timescale 1ns/1ns
`include "cpu16_config.svh"

module cpu16_checker import cpu16_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [15:0] imem_addr,
    input  logic [15:0] imem_data,
    input  logic        dmem_en,
    input  logic        dmem_we,
    input  logic [15:0] dmem_addr,
    input  logic [15:0] dmem_wdata,
    input  logic [15:0] dmem_rdata,
    input  logic        halted,
    input  int          test_id,
    input  logic        test_done,
    output int          n_pass,
    output int          n_fail
);

    // Architectural state of the model
    logic [15:0] regs [16];
    logic [15:0] pc;
    logic        halt;
    logic        flag_z;
    logic        flag_v;
    logic        flag_n;
    int          errs   = 0;
    int          passed = 0;
    int          failed = 0;

    assign n_pass = passed;
    assign n_fail = failed;

    task automatic compare(input string what, input logic [15:0] exp, input logic [15:0] act);
        if (exp !== act) begin
            $display("FAILED prog_%0d %s expected 0x%04h actual 0x%04h",
                     test_id, what, exp, act);
            errs++;
        end
    endtask

    task automatic reset_model();
        for (int i = 0; i < 16; i++) begin
            regs[i] = 16'h0000;
        end
        pc     = `CPU16_RESET_PC;
        halt   = 1'b0;
        flag_z = 1'b0;
        flag_v = 1'b0;
        flag_n = 1'b0;
    endtask

    // Arithmetic updates Z, V and N, logic and shifts update Z alone
    task automatic set_flags(input logic [15:0] res, input logic v, input logic all);
        flag_z = (res == 16'h0000);
        if (all) begin
            flag_v = v;
            flag_n = res[15];
        end
    endtask

    // Clamp to the signed 16-bit range, the top bit reports saturation
    function automatic logic [16:0] sat16(input int s);
        if (s > 32767) begin
            return {1'b1, 16'h7fff};
        end
        if (s < -32768) begin
            return {1'b1, 16'h8000};
        end
        return {1'b0, 16'(s)};
    endfunction

    function automatic logic cond_true(input cond_e c);
        case (c)
            COND_NE: return !flag_z;
            COND_EQ: return flag_z;
            COND_GT: return !flag_z && !flag_n;
            COND_LT: return flag_n;
            COND_GE: return flag_z || !flag_n;
            COND_LE: return flag_z || flag_n;
            COND_OV: return flag_v;
            default: return 1'b1;
        endcase
    endfunction

    // Checks the memory port for the fetched word, then retires it
    task automatic step();
        logic [15:0] instr;
        logic [15:0] a;
        logic [15:0] b;
        logic [15:0] res;
        logic [15:0] npc;
        logic [15:0] addr;
        logic [3:0]  rd;
        logic [3:0]  sh;
        logic        wr;
        logic        vv;
        logic        is_mem;
        opcode_e     op;
        int          s;
        instr  = imem_data;
        op     = opcode_e'(instr[15:12]);
        rd     = instr[11:8];
        sh     = instr[3:0];
        a      = regs[instr[7:4]];
        b      = regs[instr[3:0]];
        res    = 16'h0000;
        wr     = 1'b1;
        vv     = 1'b0;
        npc    = pc + 16'd2;
        is_mem = (op == OP_LW) || (op == OP_SW);
        // Word offset in the low nibble, signed and turned into bytes
        addr   = a + 16'(2 * int'($signed(instr[3:0])));

        compare("dmem_en", 16'(is_mem), 16'(dmem_en));
        compare("dmem_we", 16'(op == OP_SW), 16'(dmem_we));
        if (is_mem && dmem_en) begin
            compare("dmem_addr", addr, dmem_addr);
        end
        if (op == OP_SW) begin
            compare("dmem_wdata", regs[rd], dmem_wdata);
        end

        case (op)
            OP_ADD, OP_SUB: begin
                if (op == OP_ADD) begin
                    s = int'($signed(a)) + int'($signed(b));
                end else begin
                    s = int'($signed(a)) - int'($signed(b));
                end
                {vv, res} = sat16(s);
                set_flags(res, vv, 1'b1);
            end
            OP_XOR: begin
                res = a ^ b;
                set_flags(res, 1'b0, 1'b0);
            end
            // Four sign-extended bytes summed, no flags
            OP_RED: begin
                s = int'($signed(a[15:8])) + int'($signed(a[7:0]))
                  + int'($signed(b[15:8])) + int'($signed(b[7:0]));
                res = 16'(s);
            end
            OP_SLL: begin
                res = a << sh;
                set_flags(res, 1'b0, 1'b0);
            end
            OP_SRA: begin
                res = $signed(a) >>> sh;
                set_flags(res, 1'b0, 1'b0);
            end
            OP_ROR: begin
                res = (a >> sh) | (a << (16 - int'(sh)));
                set_flags(res, 1'b0, 1'b0);
            end
            // Each nibble saturates to 7 or -8 on its own
            OP_PADDSB: begin
                for (int i = 0; i < 4; i++) begin
                    s = int'($signed(a[4*i +: 4])) + int'($signed(b[4*i +: 4]));
                    if (s > 7) begin
                        res[4*i +: 4] = 4'h7;
                        vv = 1'b1;
                    end else if (s < -8) begin
                        res[4*i +: 4] = 4'h8;
                        vv = 1'b1;
                    end else begin
                        res[4*i +: 4] = 4'(s);
                    end
                end
                set_flags(res, vv, 1'b1);
            end
            OP_LW:  res = dmem_rdata;
            OP_SW:  wr = 1'b0;
            OP_LLB: res = {regs[rd][15:8], instr[7:0]};
            OP_LHB: res = {instr[7:0], regs[rd][7:0]};
            OP_B: begin
                wr = 1'b0;
                if (cond_true(cond_e'(instr[11:9]))) begin
                    npc = npc + 16'(2 * int'($signed(instr[8:0])));
                end
            end
            OP_BR: begin
                wr = 1'b0;
                if (cond_true(cond_e'(instr[11:9]))) begin
                    npc = a;
                end
            end
            OP_PCS: res = pc + 16'd2;
            // HLT keeps the PC on its own word
            default: begin
                wr   = 1'b0;
                npc  = pc;
                halt = 1'b1;
            end
        endcase

        // r0 stays zero whatever is written to it
        if (wr && rd != 4'd0) begin
            regs[rd] = res;
        end
        pc = npc;
    endtask

    always @(negedge clk) begin
        if (!rst_n) begin
            reset_model();
            compare("imem_addr in reset", `CPU16_RESET_PC, imem_addr);
            compare("dmem_en in reset", 16'h0000, 16'(dmem_en));
            compare("dmem_we in reset", 16'h0000, 16'(dmem_we));
            compare("halted in reset", 16'h0000, 16'(halted));
        end else begin
            compare("imem_addr", pc, imem_addr);
            compare("halted", 16'(halt), 16'(halted));
            if (halt) begin
                compare("dmem_en after HLT", 16'h0000, 16'(dmem_en));
                compare("dmem_we after HLT", 16'h0000, 16'(dmem_we));
            end else begin
                step();
            end
        end
        // One line per finished program
        if (test_done) begin
            if (errs == 0) begin
                $display("prog_%0d: pass", test_id);
                passed++;
            end else begin
                $display("prog_%0d: fail, %0d mismatches", test_id, errs);
                failed++;
            end
            errs = 0;
        end
    end

endmodule

//--- bench/tb_cpu16.sv
// *************************************************************************
// Random programs from seed 32'hfe9a, both memories answer in the same cycle
// *************************************************************************
`timescale 1ns/1ns
`include "cpu16_config.svh"

module tb_cpu16;

    localparam int NTESTS       = 8;
    // A load at word 0 and the preload take words 0 to 30, the body runs up to this word
    localparam int BODY_END     = 78;
    localparam int HALT_TIMEOUT = 400;
    // Cycles watched after halted rises
    localparam int WINDOW       = 8;

    logic                    clk;
    logic                    rst_n;
    logic [`CPU16_WIDTH-1:0] imem_addr;
    logic [`CPU16_WIDTH-1:0] imem_data;
    logic                    dmem_en;
    logic                    dmem_we;
    logic [`CPU16_WIDTH-1:0] dmem_addr;
    logic [`CPU16_WIDTH-1:0] dmem_wdata;
    logic [`CPU16_WIDTH-1:0] dmem_rdata;
    logic                    halted;
    logic                    test_done;
    int                      test_id;
    int                      n_pass;
    int                      n_fail;
    int                      seed;
    int                      plen;

    logic [15:0] imem [128];
    // Sparse data memory, locations never written come from fill()
    logic [15:0] dmem [logic [15:0]];

    cpu16 dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .imem_addr  (imem_addr),
        .imem_data  (imem_data),
        .dmem_en    (dmem_en),
        .dmem_we    (dmem_we),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_rdata (dmem_rdata),
        .halted     (halted)
    );

    cpu16_checker chk (
        .clk        (clk),
        .rst_n      (rst_n),
        .imem_addr  (imem_addr),
        .imem_data  (imem_data),
        .dmem_en    (dmem_en),
        .dmem_we    (dmem_we),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_rdata (dmem_rdata),
        .halted     (halted),
        .test_id    (test_id),
        .test_done  (test_done),
        .n_pass     (n_pass),
        .n_fail     (n_fail)
    );

    // Uniform value in 0 to n-1 from the seeded generator
    function automatic int rnd(input int n);
        int r;
        r = $random(seed);
        return (r & 32'h7fff_ffff) % n;
    endfunction

    // Swapped bytes mixed with a constant, so every address bit matters
    function automatic logic [15:0] fill(input logic [15:0] a);
        return {a[7:0], a[15:8]} ^ 16'h3c5a;
    endfunction

    function automatic logic [15:0] dmem_read(input logic [15:0] a);
        if (dmem.exists(a)) begin
            return dmem[a];
        end
        return fill(a);
    endfunction

    task automatic emit(input logic [15:0] word);
        imem[plen] = word;
        plen++;
    endtask

    task automatic build_program();
        int          op;
        int          rx;
        int          k;
        int          br_ok;
        logic [15:0] tgt;
        plen  = 0;
        br_ok = 0;
        // Words past the program are HLT, so a stray PC still stops
        for (int i = 0; i < 128; i++) begin
            imem[i] = 16'hf000;
        end
        // Word 0 is a load, so the data port decodes as active all through reset
        emit({4'h8, 4'h1, 4'h0, 4'h0});
        // Every register starts from a full random word
        for (int r = 1; r < 16; r++) begin
            emit({4'ha, 4'(r), 8'(rnd(256))});
            emit({4'hb, 4'(r), 8'(rnd(256))});
        end
        while (plen < BODY_END) begin
            // HLT is never drawn for the body
            op = rnd(15);
            // A BR triple starts beyond the reach of every earlier forward branch
            if (op == 13 && (plen + 3 > BODY_END || plen < br_ok)) begin
                op = 0;
            end
            if (op == 13) begin
                // LLB and LHB build a forward target for the BR that follows
                rx  = 1 + rnd(15);
                k   = rnd((BODY_END - plen - 3 < 3) ? BODY_END - plen - 2 : 4);
                tgt = 16'(2 * (plen + 3 + k));
                emit({4'ha, 4'(rx), tgt[7:0]});
                emit({4'hb, 4'(rx), tgt[15:8]});
                emit({4'hd, 3'(rnd(8)), 1'b0, 4'(rx), 4'h0});
                br_ok = plen + 3;
            end else if (op == 12) begin
                // Forward skip of 0 to 3 words that never leaves the body
                k = rnd((BODY_END - plen < 4) ? BODY_END - plen : 4);
                emit({4'hc, 3'(rnd(8)), 9'(k)});
                br_ok = plen + 3;
            end else begin
                emit({4'(op), 4'(rnd(16)), 4'(rnd(16)), 4'(rnd(16))});
            end
        end
        // r1 to r15 go to the words around address 0, based on r0
        for (int r = 1; r < 16; r++) begin
            emit({4'h9, 4'(r), 4'h0, 4'(r - 8)});
        end
        emit(16'hf000);
    endtask

    task automatic wait_halted(input int t);
        int cycles;
        cycles = 0;
        while (!halted && cycles < HALT_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (!halted) begin
            $display("prog_%0d: halted never rose within %0d cycles", t, HALT_TIMEOUT);
            $display("sim failed");
            $finish;
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Instruction word 1 ns after the edge, load data once the address settles
    initial begin
        imem_data  = 16'h0000;
        dmem_rdata = 16'h0000;
        forever begin
            @(posedge clk);
            #1;
            imem_data = imem[imem_addr[7:1]];
            #1;
            dmem_rdata = dmem_read(dmem_addr);
        end
    end

    // Stores land at the edge, the array is cleared during every reset
    always @(negedge clk) begin
        if (!rst_n) begin
            dmem.delete();
        end else if (dmem_en && dmem_we) begin
            dmem[dmem_addr] = dmem_wdata;
        end
    end

    initial begin
        seed      = 32'hfe9a;
        rst_n     = 1'b0;
        test_done = 1'b0;
        test_id   = 0;
        for (int t = 0; t < NTESTS; t++) begin
            test_id = t;
            build_program();
            rst_n = 1'b0;
            repeat (5) @(posedge clk);
            #1;
            rst_n = 1'b1;
            wait_halted(t);
            // The checker watches the frozen PC and the quiet data port here
            repeat (WINDOW) @(posedge clk);
            #1;
            test_done = 1'b1;
            @(posedge clk);
            #1;
            test_done = 1'b0;
        end
        $display("tests %0d, passed %0d, failed %0d", NTESTS, n_pass, n_fail);
        if (n_fail == 0 && n_pass == NTESTS) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

//--- cpu16.f
+incdir+hw
hw/cpu16_pkg.sv
hw/ctrl_if.sv
hw/control.sv
hw/alu.sv
hw/reg_file.sv
hw/pc_unit.sv
hw/cpu16.sv
bench/cpu16_checker.sv
bench/tb_cpu16.sv

//--- run_sim.sh
#!/bin/sh
# Builds the cpu16 testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_cpu16 -f cpu16.f -Mdir obj_dir

./obj_dir/Vtb_cpu16 | tee sim.log

# The run counts as passed only if the pass line is in the log
grep -q "^sim passed$" sim.log
